// ==== flist.f ====
source/fpss_cfg_pkg.sv
source/fpss_isa_pkg.sv
source/fpss_issue.sv
source/fpss_issue_fifo.sv
source/fpss_regfile.sv
source/fpss_exec.sv
source/fpss_top.sv
dv/tb_fpss.sv

// ==== Makefile ====
SIM   := verilator
FLAGS := --binary --timing -j 0
TOP   := tb_fpss
FLIST := flist.f
BUILD := obj_dir
LOG   := sim.log
PASS  := Test passed

SRCS := $(shell grep -v '^+' $(FLIST))
BIN  := $(BUILD)/V$(TOP)

.PHONY: all run clean

all: run

# rebuilt only when a source or the file list changes
$(BIN): $(SRCS) $(FLIST)
	$(SIM) $(FLAGS) --top-module $(TOP) --Mdir $(BUILD) -f $(FLIST)

run: $(BIN)
	./$(BIN) > $(LOG) 2>&1; cat $(LOG)
	@grep -q "^$(PASS)$$" $(LOG) || (echo "simulation did not pass, see $(LOG)"; exit 1)

clean:
	rm -rf $(BUILD) $(LOG)

// ==== dv/tb_fpss.sv ====
/*
 * Directed testbench for the FP coprocessor top level. Drives the issue port on
 * the falling edge, keeps a model of the FP registers and checks every response.
 */

`timescale 1ns/1ps
`default_nettype none

module tb_fpss;

  localparam int unsigned DEPTH   = fpss_cfg_pkg::FIFO_DEPTH_DEFAULT;
  localparam int          TIMEOUT = 20;

  logic                      clk_i;
  logic                      rst_ni;
  logic                      issue_valid;
  logic                      issue_ready;
  fpss_isa_pkg::issue_req_t  issue_req;
  fpss_isa_pkg::issue_resp_t issue_resp;
  logic                      result_valid;
  logic                      result_ready;
  fpss_isa_pkg::result_t     result;

  // reference copy of the FP registers
  logic [fpss_cfg_pkg::XLEN-1:0] fpr_model [fpss_cfg_pkg::NUM_FPR];
  logic [31:0]                   rng_state;
  logic [fpss_cfg_pkg::ID_W-1:0] next_id;
  int                            checks;
  int                            errors;

  fpss_top #(
    .FIFO_DEPTH (DEPTH)
  ) UUT (
    .clk_i          (clk_i),
    .rst_ni         (rst_ni),
    .issue_valid_i  (issue_valid),
    .issue_ready_o  (issue_ready),
    .issue_req_i    (issue_req),
    .issue_resp_o   (issue_resp),
    .result_valid_o (result_valid),
    .result_ready_i (result_ready),
    .result_o       (result)
  );

  initial clk_i = 1'b0;
  always #4 clk_i = ~clk_i;

  function automatic logic [31:0] next_rand();
    rng_state = rng_state ^ (rng_state << 13);
    rng_state = rng_state ^ (rng_state >> 17);
    rng_state = rng_state ^ (rng_state << 5);
    return rng_state;
  endfunction

  function automatic logic [4:0] rand_reg();
    logic [31:0] x;
    x = next_rand();
    return x[4:0];
  endfunction

  // R-type word in the OP-FP group
  function automatic logic [31:0] encode(input logic [6:0] funct7, input logic [4:0] rs2,
                                         input logic [4:0] rs1, input logic [2:0] funct3,
                                         input logic [4:0] rd);
    return {funct7, rs2, rs1, funct3, rd, fpss_isa_pkg::OPCODE_OP_FP};
  endfunction

  // magnitude from a with the sign picked by funct3
  function automatic logic [31:0] sign_inject(input logic [2:0] funct3, input logic [31:0] a,
                                              input logic [31:0] b);
    logic s;
    case (funct3)
      3'b000:  s = b[31];
      3'b001:  s = ~b[31];
      default: s = a[31] ^ b[31];
    endcase
    return {s, a[30:0]};
  endfunction

  // each request takes a fresh id
  function automatic fpss_isa_pkg::issue_req_t make_req(input logic [31:0] instr,
                                                        input logic [31:0] operand);
    fpss_isa_pkg::issue_req_t req;
    req.instr     = instr;
    req.rs1       = operand;
    req.rs1_valid = 1'b1;
    req.id        = next_id;
    next_id       = next_id + 1'b1;
    return req;
  endfunction

  task automatic check_resp(input fpss_isa_pkg::issue_resp_t got,
                            input fpss_isa_pkg::issue_resp_t exp, input string what);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("Mismatch at %0t: %s response accept=%0b wb=%0b, expected accept=%0b wb=%0b",
               $time, what, got.accept, got.writeback, exp.accept, exp.writeback);
    end
  endtask

  task automatic check_result(input fpss_isa_pkg::result_t got,
                              input fpss_isa_pkg::result_t exp, input string what);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("Mismatch at %0t: %s result id=%0d rd=%0d data=%h, expected id=%0d rd=%0d data=%h",
               $time, what, got.id, got.rd, got.data, exp.id, exp.rd, exp.data);
    end
  endtask

  // offer one instruction and wait up to max_wait cycles for ready
  task automatic issue(input fpss_isa_pkg::issue_req_t req, input int max_wait,
                       output fpss_isa_pkg::issue_resp_t resp, output bit done);
    int n;
    n = 0;
    @(negedge clk_i);
    issue_valid = 1'b1;
    issue_req   = req;
    #2;
    while (!issue_ready && n < max_wait) begin
      @(negedge clk_i);
      #2;
      n++;
    end
    done = issue_ready;
    resp = issue_resp;
    // transfer happens at this rising edge
    if (done) begin
      @(posedge clk_i);
    end
    @(negedge clk_i);
    issue_valid = 1'b0;
  endtask

  task automatic offer(input fpss_isa_pkg::issue_req_t req, input logic accept,
                       input logic writeback, input string what);
    fpss_isa_pkg::issue_resp_t resp;
    fpss_isa_pkg::issue_resp_t exp;
    bit                        done;
    exp.accept    = accept;
    exp.writeback = writeback;
    issue(req, TIMEOUT, resp, done);
    if (!done) begin
      errors++;
      $display("%s was never taken by the issue port at %0t", what, $time);
    end else begin
      check_resp(resp, exp, what);
    end
  endtask

  // wait for a result that is drained at the next edge while ready is high
  task automatic collect(output fpss_isa_pkg::result_t res, output bit done);
    int n;
    n = 0;
    #2;
    while (!result_valid && n < TIMEOUT) begin
      @(negedge clk_i);
      #2;
      n++;
    end
    done = result_valid;
    res  = result;
    if (done && result_ready) begin
      @(posedge clk_i);
    end
  endtask

  task automatic write_fpr(input logic [4:0] rd, input logic [31:0] value);
    offer(make_req(encode(fpss_isa_pkg::FUNCT7_FMV_W_X, 5'd0, 5'd0, fpss_isa_pkg::FUNCT3_FMV,
                          rd), value), 1'b1, 1'b0, "FMV.W.X");
    fpr_model[rd] = value;
  endtask

  // FMV.X.W of one register compared with the model
  task automatic read_back(input logic [4:0] rs);
    fpss_isa_pkg::issue_req_t req;
    fpss_isa_pkg::result_t    res;
    fpss_isa_pkg::result_t    exp;
    logic [4:0]               rd;
    bit                       done;
    rd  = rand_reg();
    req = make_req(encode(fpss_isa_pkg::FUNCT7_FMV_X_W, 5'd0, rs, fpss_isa_pkg::FUNCT3_FMV,
                          rd), 32'd0);
    offer(req, 1'b1, 1'b1, "FMV.X.W");
    collect(res, done);
    exp.id   = req.id;
    exp.rd   = rd;
    exp.data = fpr_model[rs];
    if (!done) begin
      errors++;
      $display("no result came back for FMV.X.W of f%0d at %0t", rs, $time);
    end else begin
      check_result(res, exp, "FMV.X.W");
    end
  endtask

  task automatic report(input string name, input int start);
    $display("%s: %0d errors", name, errors - start);
  endtask

  task automatic test_move_round_trip();
    int          start;
    logic [4:0]  r;
    start = errors;
    checks++;
    if (result_valid !== 1'b0) begin
      errors++;
      $display("Mismatch at %0t: result valid is %b after reset, expected 0",
               $time, result_valid);
    end
    repeat (4) begin
      r = rand_reg();
      write_fpr(r, next_rand());
      read_back(r);
    end
    report("move round trip", start);
  endtask

  task automatic test_sign_inject();
    int         start;
    logic [4:0] a;
    logic [4:0] b;
    logic [4:0] d;
    logic [2:0] f3;
    start = errors;
    for (int k = 0; k < 6; k++) begin
      f3 = 3'(k % 3);
      a  = rand_reg();
      b  = rand_reg();
      d  = rand_reg();
      write_fpr(a, next_rand());
      write_fpr(b, next_rand());
      offer(make_req(encode(fpss_isa_pkg::FUNCT7_FSGNJ_S, b, a, f3, d), 32'd0), 1'b1, 1'b0,
            "FSGNJ");
      fpr_model[d] = sign_inject(f3, fpr_model[a], fpr_model[b]);
      read_back(d);
    end
    report("sign injection", start);
  endtask

  task automatic test_reject();
    int                    start;
    logic [31:0]           bad [3];
    fpss_isa_pkg::result_t res;
    bit                    done;
    start = errors;
    // FADD.S, FSGNJ with double fmt, FMV.X.W with rs2 set
    bad[0] = encode(7'b0000000, 5'd2, 5'd1, 3'b000, 5'd3);
    bad[1] = encode(fpss_isa_pkg::FUNCT7_FSGNJ_S | 7'b0000001, 5'd2, 5'd1, 3'b000, 5'd4);
    bad[2] = encode(fpss_isa_pkg::FUNCT7_FMV_X_W, 5'd1, 5'd1, 3'b000, 5'd5);
    for (int k = 0; k < 3; k++) begin
      offer(make_req(bad[k], next_rand()), 1'b0, 1'b0, "rejected");
      collect(res, done);
      checks++;
      if (done) begin
        errors++;
        $display("a result came back for rejected word %h at %0t", bad[k], $time);
      end
    end
    read_back(5'd3);
    read_back(5'd4);
    report("rejection", start);
  endtask

  task automatic test_operand_wait();
    int                       start;
    fpss_isa_pkg::issue_req_t req;
    logic [4:0]               r;
    start = errors;
    r     = rand_reg();
    req   = make_req(encode(fpss_isa_pkg::FUNCT7_FMV_W_X, 5'd0, 5'd0,
                            fpss_isa_pkg::FUNCT3_FMV, r), next_rand());
    req.rs1_valid = 1'b0;
    @(negedge clk_i);
    issue_valid = 1'b1;
    issue_req   = req;
    for (int i = 0; i < 10; i++) begin
      #2;
      checks++;
      if (issue_ready !== 1'b0) begin
        errors++;
        $display("Mismatch at %0t: issue ready is %b before the integer operand, expected 0",
                 $time, issue_ready);
      end
      @(negedge clk_i);
    end
    req.rs1_valid = 1'b1;
    offer(req, 1'b1, 1'b0, "FMV.W.X after wait");
    fpr_model[r] = req.rs1;
    read_back(r);
    report("operand wait", start);
  endtask

  task automatic test_back_pressure();
    int                        start;
    fpss_isa_pkg::issue_req_t  req;
    fpss_isa_pkg::issue_resp_t resp;
    fpss_isa_pkg::issue_resp_t exp_resp;
    fpss_isa_pkg::result_t     exp;
    fpss_isa_pkg::result_t     res;
    fpss_isa_pkg::result_t     exp_q [$];
    logic [4:0]                r;
    logic [4:0]                d;
    bit                        done;
    bit                        blocked;
    start              = errors;
    blocked            = 1'b0;
    exp_resp.accept    = 1'b1;
    exp_resp.writeback = 1'b1;
    @(negedge clk_i);
    result_ready = 1'b0;
    // ready must drop once the result slot and the FIFO are full
    for (int i = 0; i < int'(DEPTH) + 2 && !blocked; i++) begin
      r   = rand_reg();
      d   = rand_reg();
      req = make_req(encode(fpss_isa_pkg::FUNCT7_FMV_X_W, 5'd0, r, fpss_isa_pkg::FUNCT3_FMV,
                            d), 32'd0);
      issue(req, 0, resp, done);
      if (done) begin
        check_resp(resp, exp_resp, "stalled FMV.X.W");
        exp.id   = req.id;
        exp.rd   = d;
        exp.data = fpr_model[r];
        exp_q.push_back(exp);
      end else begin
        blocked = 1'b1;
      end
    end
    checks++;
    if (!blocked) begin
      errors++;
      $display("issue port stayed ready while results were stalled");
    end
    result_ready = 1'b1;
    while (exp_q.size() > 0) begin
      exp = exp_q.pop_front();
      collect(res, done);
      if (!done) begin
        errors++;
        $display("stalled result id %0d never came back", exp.id);
      end else begin
        check_result(res, exp, "drained");
      end
    end
    report("back-pressure", start);
  endtask

  initial begin
    rng_state    = 32'h8c75;
    next_id      = '0;
    checks       = 0;
    errors       = 0;
    rst_ni       = 1'b0;
    issue_valid  = 1'b0;
    issue_req    = '0;
    result_ready = 1'b1;
    for (int i = 0; i < fpss_cfg_pkg::NUM_FPR; i++) begin
      fpr_model[i] = '0;
    end
    repeat (10) @(negedge clk_i);
    rst_ni = 1'b1;
    test_move_round_trip();
    test_sign_inject();
    test_reject();
    test_operand_wait();
    test_back_pressure();
    $display("checks: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("Test passed");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== source/fpss_top.sv ====
/*
 * FP coprocessor top level behind the core offload port. Connects the issue
 * stage, the input FIFO and the execute stage and sets the FIFO depth.
 */

`timescale 1ns/1ps
`default_nettype none

module fpss_top #(
  parameter int unsigned FIFO_DEPTH = fpss_cfg_pkg::FIFO_DEPTH_DEFAULT
) (
  input  wire logic                       clk_i,
  input  wire logic                       rst_ni,
  // issue port
  input  wire logic                       issue_valid_i,
  output logic                            issue_ready_o,
  input  wire fpss_isa_pkg::issue_req_t   issue_req_i,
  output fpss_isa_pkg::issue_resp_t       issue_resp_o,
  // result port
  output logic                            result_valid_o,
  input  wire logic                       result_ready_i,
  output fpss_isa_pkg::result_t           result_o
);

  // issue to FIFO
  logic                   push_valid;
  logic                   push_ready;
  fpss_isa_pkg::offload_t push_data;
  // FIFO to execute
  logic                   pop_valid;
  logic                   pop_ready;
  fpss_isa_pkg::offload_t pop_data;

  fpss_issue u_issue (
    .issue_valid_i (issue_valid_i),
    .issue_req_i   (issue_req_i),
    .issue_ready_o (issue_ready_o),
    .issue_resp_o  (issue_resp_o),
    .push_valid_o  (push_valid),
    .push_data_o   (push_data),
    .push_ready_i  (push_ready)
  );

  fpss_issue_fifo #(
    .DEPTH (FIFO_DEPTH)
  ) u_issue_fifo (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .push_valid_i (push_valid),
    .push_data_i  (push_data),
    .push_ready_o (push_ready),
    .pop_valid_o  (pop_valid),
    .pop_data_o   (pop_data),
    .pop_ready_i  (pop_ready)
  );

  fpss_exec u_exec (
    .clk_i          (clk_i),
    .rst_ni         (rst_ni),
    .pop_valid_i    (pop_valid),
    .pop_data_i     (pop_data),
    .pop_ready_o    (pop_ready),
    .result_valid_o (result_valid_o),
    .result_ready_i (result_ready_i),
    .result_o       (result_o)
  );

endmodule

`default_nettype wire

// ==== source/fpss_exec.sv ====
/*
 * Execute stage. Pops one predecoded instruction per cycle, reads its FP
 * sources and either writes rd or loads the integer result for the core.
 */

`timescale 1ns/1ps
`default_nettype none

module fpss_exec (
  input  wire logic                    clk_i,
  input  wire logic                    rst_ni,
  input  wire logic                    pop_valid_i,
  input  wire fpss_isa_pkg::offload_t  pop_data_i,
  output logic                         pop_ready_o,
  output logic                         result_valid_o,
  input  wire logic                    result_ready_i,
  output fpss_isa_pkg::result_t        result_o
);

  localparam int unsigned SIGN = fpss_cfg_pkg::XLEN - 1;

  logic [fpss_cfg_pkg::XLEN-1:0] fpr_a;
  logic [fpss_cfg_pkg::XLEN-1:0] fpr_b;
  logic [fpss_cfg_pkg::XLEN-1:0] value;
  logic                          pop;
  logic                          is_int_wb;
  logic                          fpr_we;
  logic                          result_valid_q;
  fpss_isa_pkg::result_t         result_q;

  // accept a new pop when the result slot is free or drains this cycle
  assign pop_ready_o = !result_valid_q || result_ready_i;
  assign pop         = pop_valid_i && pop_ready_o;

  assign is_int_wb = (pop_data_i.op == fpss_isa_pkg::OP_FMV_X_W);
  assign fpr_we    = pop && !is_int_wb;

  fpss_regfile u_regfile (
    .clk_i     (clk_i),
    .rst_ni    (rst_ni),
    .raddr_a_i (pop_data_i.rs1),
    .raddr_b_i (pop_data_i.rs2),
    .rdata_a_o (fpr_a),
    .rdata_b_o (fpr_b),
    .waddr_i   (pop_data_i.rd),
    .wdata_i   (value),
    .we_i      (fpr_we)
  );

  // sign injection keeps the magnitude of rs1
  always_comb begin
    case (pop_data_i.op)
      fpss_isa_pkg::OP_FSGNJ: begin
        value = {fpr_b[SIGN], fpr_a[SIGN-1:0]};
      end
      fpss_isa_pkg::OP_FSGNJN: begin
        value = {~fpr_b[SIGN], fpr_a[SIGN-1:0]};
      end
      fpss_isa_pkg::OP_FSGNJX: begin
        value = {fpr_a[SIGN] ^ fpr_b[SIGN], fpr_a[SIGN-1:0]};
      end
      fpss_isa_pkg::OP_FMV_W_X: begin
        // integer operand moves in bit for bit
        value = pop_data_i.operand;
      end
      default: begin
        // FMV.X.W passes rs1 through to the core
        value = fpr_a;
      end
    endcase
  end

  // a new load at the drain edge replaces the old result
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      result_valid_q <= 1'b0;
      result_q       <= '0;
    end else begin
      if (pop && is_int_wb) begin
        result_valid_q <= 1'b1;
        result_q.id    <= pop_data_i.id;
        result_q.rd    <= pop_data_i.rd;
        result_q.data  <= value;
      end else if (result_ready_i) begin
        result_valid_q <= 1'b0;
      end
    end
  end

  assign result_valid_o = result_valid_q;
  assign result_o       = result_q;

endmodule

`default_nettype wire

// ==== source/fpss_regfile.sv ====
/*
 * Floating-point register file of NUM_FPR words with two combinational read
 * ports and one write port that takes effect at the clock edge.
 */

`timescale 1ns/1ps
`default_nettype none

module fpss_regfile (
  input  wire logic                                  clk_i,
  input  wire logic                                  rst_ni,
  input  wire logic [fpss_cfg_pkg::REG_ADDR_W-1:0]   raddr_a_i,
  input  wire logic [fpss_cfg_pkg::REG_ADDR_W-1:0]   raddr_b_i,
  output logic [fpss_cfg_pkg::XLEN-1:0]              rdata_a_o,
  output logic [fpss_cfg_pkg::XLEN-1:0]              rdata_b_o,
  input  wire logic [fpss_cfg_pkg::REG_ADDR_W-1:0]   waddr_i,
  input  wire logic [fpss_cfg_pkg::XLEN-1:0]         wdata_i,
  input  wire logic                                  we_i
);

  logic [fpss_cfg_pkg::XLEN-1:0] regs_q [fpss_cfg_pkg::NUM_FPR];

  // f0 is an ordinary register unlike x0
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      for (int i = 0; i < fpss_cfg_pkg::NUM_FPR; i++) begin
        regs_q[i] <= '0;
      end
    end else if (we_i) begin
      regs_q[waddr_i] <= wdata_i;
    end
  end

  assign rdata_a_o = regs_q[raddr_a_i];
  assign rdata_b_o = regs_q[raddr_b_i];

endmodule

`default_nettype wire

// ==== source/fpss_issue_fifo.sv ====
/*
 * Circular buffer of predecoded instructions between issue and execute.
 * Without fall-through an entry can be popped one cycle after its push at
 * the earliest. Push and pop may happen in the same cycle.
 */

`timescale 1ns/1ps
`default_nettype none

module fpss_issue_fifo #(
  parameter int unsigned DEPTH = fpss_cfg_pkg::FIFO_DEPTH_DEFAULT
) (
  input  wire logic                    clk_i,
  input  wire logic                    rst_ni,
  input  wire logic                    push_valid_i,
  input  wire fpss_isa_pkg::offload_t  push_data_i,
  output logic                         push_ready_o,
  output logic                         pop_valid_o,
  output fpss_isa_pkg::offload_t       pop_data_o,
  input  wire logic                    pop_ready_i
);

  // keep pointer width nonzero for a single-entry buffer
  localparam int unsigned PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int unsigned CNT_W = $clog2(DEPTH + 1);

  fpss_isa_pkg::offload_t mem_q [DEPTH];
  logic [PTR_W-1:0]       wr_ptr_q;
  logic [PTR_W-1:0]       rd_ptr_q;
  logic [CNT_W-1:0]       count_q;
  logic                   push;
  logic                   pop;

  // full and empty come straight from the count
  assign push_ready_o = (count_q != CNT_W'(DEPTH));
  assign pop_valid_o  = (count_q != '0);
  assign pop_data_o   = mem_q[rd_ptr_q];

  assign push = push_valid_i && push_ready_o;
  assign pop  = pop_valid_o && pop_ready_i;

  // storage is written only on push
  always_ff @(posedge clk_i) begin
    if (push) begin
      mem_q[wr_ptr_q] <= push_data_i;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (push) begin
        wr_ptr_q <= (wr_ptr_q == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr_q + 1'b1;
      end
      if (pop) begin
        rd_ptr_q <= (rd_ptr_q == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr_q + 1'b1;
      end
      // count holds when push and pop coincide
      if (push && !pop) begin
        count_q <= count_q + 1'b1;
      end else if (pop && !push) begin
        count_q <= count_q - 1'b1;
      end
    end
  end

endmodule

`default_nettype wire

// ==== source/fpss_issue.sv ====
/*
 * Issue stage. Predecodes the offered instruction, answers accept and
 * writeback in the same cycle and pushes accepted instructions to the FIFO.
 */

`timescale 1ns/1ps
`default_nettype none

module fpss_issue (
  input  wire logic                      issue_valid_i,
  input  wire fpss_isa_pkg::issue_req_t  issue_req_i,
  output logic                           issue_ready_o,
  output fpss_isa_pkg::issue_resp_t      issue_resp_o,
  output logic                           push_valid_o,
  output fpss_isa_pkg::offload_t         push_data_o,
  input  wire logic                      push_ready_i
);

  logic [6:0]           opcode;
  logic [2:0]           funct3;
  logic [6:0]           funct7;
  logic [4:0]           rs2_field;
  fpss_isa_pkg::fp_op_e op;
  logic                 accept;
  logic                 need_rs1;

  // instruction fields
  assign opcode    = issue_req_i.instr[6:0];
  assign funct3    = issue_req_i.instr[14:12];
  assign funct7    = issue_req_i.instr[31:25];
  assign rs2_field = issue_req_i.instr[24:20];

  // match against kept encodings
  // fmt bits are covered by funct7
  always_comb begin
    op     = fpss_isa_pkg::OP_FSGNJ;
    accept = 1'b0;
    if (opcode == fpss_isa_pkg::OPCODE_OP_FP) begin
      case (funct7)
        fpss_isa_pkg::FUNCT7_FSGNJ_S: begin
          accept = 1'b1;
          case (funct3)
            fpss_isa_pkg::FUNCT3_FSGNJ:  op = fpss_isa_pkg::OP_FSGNJ;
            fpss_isa_pkg::FUNCT3_FSGNJN: op = fpss_isa_pkg::OP_FSGNJN;
            fpss_isa_pkg::FUNCT3_FSGNJX: op = fpss_isa_pkg::OP_FSGNJX;
            default:                     accept = 1'b0;
          endcase
        end
        fpss_isa_pkg::FUNCT7_FMV_X_W: begin
          op     = fpss_isa_pkg::OP_FMV_X_W;
          accept = (funct3 == fpss_isa_pkg::FUNCT3_FMV) && (rs2_field == 5'd0);
        end
        fpss_isa_pkg::FUNCT7_FMV_W_X: begin
          op     = fpss_isa_pkg::OP_FMV_W_X;
          accept = (funct3 == fpss_isa_pkg::FUNCT3_FMV) && (rs2_field == 5'd0);
        end
        default: ;
      endcase
    end
  end

  // only FMV.W.X consumes the integer operand
  assign need_rs1 = accept && (op == fpss_isa_pkg::OP_FMV_W_X);

  // rejected instructions complete too but still wait for FIFO space
  assign issue_ready_o = push_ready_i && (!need_rs1 || issue_req_i.rs1_valid);

  assign issue_resp_o.accept    = accept;
  assign issue_resp_o.writeback = accept && (op == fpss_isa_pkg::OP_FMV_X_W);

  // push accepted ones only with register fields extracted here once
  assign push_valid_o        = issue_valid_i && issue_ready_o && accept;
  assign push_data_o.op      = op;
  assign push_data_o.rd      = issue_req_i.instr[11:7];
  assign push_data_o.rs1     = issue_req_i.instr[19:15];
  assign push_data_o.rs2     = issue_req_i.instr[24:20];
  assign push_data_o.operand = issue_req_i.rs1;
  assign push_data_o.id      = issue_req_i.id;

endmodule

`default_nettype wire

// ==== source/fpss_isa_pkg.sv ====
/*
 * RV32F encodings of the kept instructions, the operation enum and the
 * packed structs passed across the issue, FIFO, execute and result ports.
 */

`default_nettype none

package fpss_isa_pkg;

  // major opcode of the OP-FP group
  parameter logic [6:0] OPCODE_OP_FP = 7'b1010011;

  // funct7 of the groups
  // fmt field [26:25] is 00 for single precision
  parameter logic [6:0] FUNCT7_FSGNJ_S = 7'b0010000;
  parameter logic [6:0] FUNCT7_FMV_X_W = 7'b1110000;
  parameter logic [6:0] FUNCT7_FMV_W_X = 7'b1111000;

  // funct3 selects the sign injection variant
  parameter logic [2:0] FUNCT3_FSGNJ  = 3'b000;
  parameter logic [2:0] FUNCT3_FSGNJN = 3'b001;
  parameter logic [2:0] FUNCT3_FSGNJX = 3'b010;
  parameter logic [2:0] FUNCT3_FMV    = 3'b000;

  typedef enum logic [2:0] {
    OP_FSGNJ,
    OP_FSGNJN,
    OP_FSGNJX,
    OP_FMV_W_X,
    OP_FMV_X_W
  } fp_op_e;

  // instruction offered by the core
  typedef struct packed {
    logic [fpss_cfg_pkg::XLEN-1:0] instr;
    logic [fpss_cfg_pkg::XLEN-1:0] rs1;
    logic                          rs1_valid;
    logic [fpss_cfg_pkg::ID_W-1:0] id;
  } issue_req_t;

  // writeback tells the core to expect an integer result
  typedef struct packed {
    logic accept;
    logic writeback;
  } issue_resp_t;

  // predecoded FIFO entry
  typedef struct packed {
    fp_op_e                              op;
    logic [fpss_cfg_pkg::REG_ADDR_W-1:0] rd;
    logic [fpss_cfg_pkg::REG_ADDR_W-1:0] rs1;
    logic [fpss_cfg_pkg::REG_ADDR_W-1:0] rs2;
    logic [fpss_cfg_pkg::XLEN-1:0]       operand;
    logic [fpss_cfg_pkg::ID_W-1:0]       id;
  } offload_t;

  // integer result returned to the core
  typedef struct packed {
    logic [fpss_cfg_pkg::ID_W-1:0]       id;
    logic [fpss_cfg_pkg::REG_ADDR_W-1:0] rd;
    logic [fpss_cfg_pkg::XLEN-1:0]       data;
  } result_t;

endpackage

`default_nettype wire

// ==== source/fpss_cfg_pkg.sv ====
/*
 * Size parameters of the FP coprocessor data path and register file.
 * Every module and the testbench refer to these by scoped name.
 */

`default_nettype none

package fpss_cfg_pkg;

  // integer and FP data are both one 32-bit word
  parameter int unsigned XLEN = 32;

  // FP register file
  parameter int unsigned NUM_FPR    = 32;
  parameter int unsigned REG_ADDR_W = 5;

  // width of the instruction id from the core
  parameter int unsigned ID_W = 4;

  // input FIFO depth used when the top level does not override it
  parameter int unsigned FIFO_DEPTH_DEFAULT = 2;

endpackage

`default_nettype wire
